/* compile.f */
hw/lsp_extract_pkg.sv
hw/basic_ops.sv
hw/l_shl_unit.sv
hw/scratch_mem.sv
hw/lsp_prev_extract.sv
hw/lsp_extract_top.sv
verification/lsp_extract_properties.sv
verification/lsp_extract_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module lsp_extract_tb -f compile.f -o sim_lsp_extract
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_lsp_extract)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

/* verification/lsp_extract_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsp_extract_tb;
	import lsp_extract_pkg::*;

	localparam int RUN_LIMIT      = 200;     // Start to done, about 152 cycles expected
	// Tests need about 4000 cycles: two-cycle host accesses, five runs, one window sweep
	localparam int TIMEOUT_CYCLES = 20000;

	logic                clk;
	logic                reset;
	logic                start;
	logic [ADDR_W-1:0]   lsp_base, freq_prev_base, fg_base, fg_sum_inv_base, lspele_base;
	logic [ADDR_W-1:0]   host_addr;
	logic [WORD_W-1:0]   host_wdata;
	logic                host_we;
	logic                done;
	logic [WORD_W-1:0]   host_rdata;

	logic [SAMPLE_W-1:0] lsp_tab [LP_ORDER];
	logic [SAMPLE_W-1:0] fsi_tab [LP_ORDER];          // fg_sum_inv
	logic [SAMPLE_W-1:0] fp_tab  [LP_ORDER][MA_NP];   // freq_prev
	logic [SAMPLE_W-1:0] fg_tab  [LP_ORDER][MA_NP];
	logic [WORD_W-1:0]   expect_tab [2][LP_ORDER];
	logic [WORD_W-1:0]   shadow [MEM_DEPTH];           // Last word the host put there
	int                  errors, checks, cycle_count;

	lsp_extract_top DUT (.*);

	bind lsp_prev_extract lsp_extract_properties u_props (
		.clk(clk), .reset(reset), .done(done), .write_en(write_en),
		.write_addr(write_addr), .lspele_base(lspele_base),
		.shl_ready(shl_ready), .shl_done(shl_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Bit-exact fixed-point model
	////////////////////////////////////////////////////////////
	function automatic logic [WORD_W-1:0] clamp32(input longint v);
		if (v > 64'sd2147483647)
			return 32'h7FFF_FFFF;
		if (v < -64'sd2147483648)
			return 32'h8000_0000;
		return v[WORD_W-1:0];
	endfunction

	function automatic logic [WORD_W-1:0] mult_sat(input logic [SAMPLE_W-1:0] a, b);
		return clamp32(2 * longint'($signed(a)) * longint'($signed(b)));
	endfunction

	function automatic logic [WORD_W-1:0] msu_sat(input logic [WORD_W-1:0] c,
		input logic [SAMPLE_W-1:0] a, b);
		return clamp32(longint'($signed(c)) - longint'($signed(mult_sat(a, b))));
	endfunction

	// Clamping the full product equals clamping bit by bit
	function automatic logic [WORD_W-1:0] shl_sat(input logic [WORD_W-1:0] a);
		return clamp32(longint'($signed(a)) * (longint'(1) << LSP_SHL));
	endfunction

	function automatic logic [WORD_W-1:0] expected_word(input int j);
		logic [WORD_W-1:0] acc;
		logic [WORD_W-1:0] scaled;
		int                k;
		acc = {lsp_tab[j], 16'h0000};
		for (k = 0; k < MA_NP; k++)
			acc = msu_sat(acc, fp_tab[j][k], fg_tab[j][k]);
		scaled = shl_sat(mult_sat(acc[WORD_W-1 -: SAMPLE_W], fsi_tab[j]));
		return {16'h0000, scaled[WORD_W-1 -: SAMPLE_W]};
	endfunction

	function automatic logic [WORD_W-1:0] fill_pattern(input logic [ADDR_W-1:0] a);
		return {5'h15, a, 5'h0A, ~a};
	endfunction

	////////////////////////////////////////////////////////////
	// Host port and engine control
	////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		@(posedge clk);
		host_addr  <= addr;
		host_wdata <= data;
		host_we    <= 1'b1;
		shadow[addr] = data;
		@(posedge clk);
		host_we <= 1'b0;
	endtask

	task automatic compare_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] exp);
		logic [WORD_W-1:0] got;
		@(posedge clk);
		host_addr <= addr;
		host_we   <= 1'b0;
		@(posedge clk);   // Registered read
		@(negedge clk);
		got = host_rdata;
		check_value($sformatf("host_rdata[%h]", addr), got, exp);
	endtask

	task automatic fill_random();
		int j;
		int k;
		for (j = 0; j < LP_ORDER; j++)
		begin
			lsp_tab[j] = SAMPLE_W'($urandom);
			fsi_tab[j] = SAMPLE_W'($urandom);
			for (k = 0; k < MA_NP; k++)
			begin
				fp_tab[j][k] = SAMPLE_W'($urandom);
				fg_tab[j][k] = SAMPLE_W'($urandom);
			end
		end
	endtask

	// Upper halves get noise, only the low sample counts
	task automatic load_tables(input logic [ADDR_W-1:0] lb, fpb, fgb, fsib, input int set);
		int j;
		int k;
		for (j = 0; j < LP_ORDER; j++)
		begin
			write_word(lb + ADDR_W'(j), {SAMPLE_W'($urandom), lsp_tab[j]});
			write_word(fsib + ADDR_W'(j), {SAMPLE_W'($urandom), fsi_tab[j]});
			for (k = 0; k < MA_NP; k++)
			begin
				write_word(fpb + ADDR_W'(4*j + k), {SAMPLE_W'($urandom), fp_tab[j][k]});
				write_word(fgb + ADDR_W'(4*j + k), {SAMPLE_W'($urandom), fg_tab[j][k]});
			end
			expect_tab[set][j] = expected_word(j);
		end
	endtask

	task automatic run_engine(input logic [ADDR_W-1:0] lb, fpb, fgb, fsib, eb);
		int   waited;
		logic seen;
		@(posedge clk);
		lsp_base        <= lb;
		freq_prev_base  <= fpb;
		fg_base         <= fgb;
		fg_sum_inv_base <= fsib;
		lspele_base     <= eb;
		start           <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < RUN_LIMIT)
		begin
			@(negedge clk);
			seen = done;
			waited++;
		end
		checks++;
		assert (seen)
		else
		begin
			errors++;
			$display("Engine gave no done pulse within %0d cycles of start", RUN_LIMIT);
		end
	endtask

	task automatic check_results(input logic [ADDR_W-1:0] eb, input int set);
		int j;
		for (j = 0; j < LP_ORDER; j++)
		begin
			shadow[eb + ADDR_W'(j)] = expect_tab[set][j];
			compare_word(eb + ADDR_W'(j), expect_tab[set][j]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic reset_and_host_access();
		logic [WORD_W-1:0] word;
		int                i;
		for (i = 0; i < 8; i++)
		begin
			@(negedge clk);
			check_value("done", {31'b0, done}, 32'h0);
		end
		word = $urandom;
		write_word(11'h7F5, word);
		compare_word(11'h7F5, word);
	endtask

	task automatic random_tables();
		fill_random();
		load_tables(11'h010, 11'h040, 11'h080, 11'h020, 0);
		run_engine(11'h010, 11'h040, 11'h080, 11'h020, 11'h030);
		check_results(11'h030, 0);
	endtask

	task automatic saturation_cases();
		int j;
		int k;
		for (j = 0; j < LP_ORDER; j++)
		begin
			lsp_tab[j] = j[0] ? 16'h7FFF : 16'h8000;   // Extreme accumulator starts
			fsi_tab[j] = (j < 5) ? 16'h7FFF : 16'h8000;
			for (k = 0; k < MA_NP; k++)
			begin
				case (j % 3)
					0:       {fp_tab[j][k], fg_tab[j][k]} = {16'h8000, 16'h8000};
					1:       {fp_tab[j][k], fg_tab[j][k]} = {16'h7FFF, 16'h7FFF};
					default: {fp_tab[j][k], fg_tab[j][k]} = {16'h8000, 16'h7FFF};
				endcase
			end
		end
		load_tables(11'h310, 11'h340, 11'h380, 11'h300, 0);
		run_engine(11'h310, 11'h340, 11'h380, 11'h300, 11'h320);
		check_results(11'h320, 0);
	endtask

	task automatic back_to_back_runs();
		int j;
		fill_random();
		load_tables(11'h100, 11'h140, 11'h180, 11'h110, 0);
		fill_random();
		load_tables(11'h200, 11'h240, 11'h280, 11'h210, 1);
		for (j = 0; j < 16; j++)
			write_word(11'h220 + ADDR_W'(j), fill_pattern(11'h220 + ADDR_W'(j)));
		run_engine(11'h100, 11'h140, 11'h180, 11'h110, 11'h120);
		check_results(11'h120, 0);
		for (j = 0; j < 16; j++)
			compare_word(11'h220 + ADDR_W'(j), shadow[11'h220 + j]);   // Second region intact
		run_engine(11'h200, 11'h240, 11'h280, 11'h210, 11'h220);
		check_results(11'h220, 1);
		check_results(11'h120, 0);
	endtask

	task automatic untouched_memory();
		int a;
		for (a = 11'h400; a < 11'h600; a++)
			write_word(ADDR_W'(a), fill_pattern(ADDR_W'(a)));
		fill_random();
		load_tables(11'h400, 11'h440, 11'h480, 11'h410, 0);
		run_engine(11'h400, 11'h440, 11'h480, 11'h410, 11'h420);
		check_results(11'h420, 0);
		for (a = 11'h400; a < 11'h600; a++)
			compare_word(ADDR_W'(a), shadow[a]);
	endtask

	initial
	begin
		void'($urandom(32'h1103));
		errors          = 0;
		checks          = 0;
		reset           = 1'b1;
		start           = 1'b0;
		lsp_base        = '0;
		freq_prev_base  = '0;
		fg_base         = '0;
		fg_sum_inv_base = '0;
		lspele_base     = '0;
		host_addr       = '0;
		host_wdata      = '0;
		host_we         = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		reset_and_host_access();
		random_tables();
		saturation_cases();
		back_to_back_runs();
		untouched_memory();

		repeat (4) @(posedge clk);
		$display("Run complete: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/lsp_extract_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module lsp_extract_properties (
	input logic                               clk,
	input logic                               reset,
	input logic                               done,
	input logic                               write_en,
	input logic [lsp_extract_pkg::ADDR_W-1:0] write_addr,
	input logic [lsp_extract_pkg::ADDR_W-1:0] lspele_base,
	input logic                               shl_ready,
	input logic                               shl_done
);
	import lsp_extract_pkg::*;

	logic shl_pending;   // Shifter launched, result not back yet

	always_ff @(posedge clk)
	begin
		if (reset)
			shl_pending <= 1'b0;
		else if (shl_ready)
			shl_pending <= 1'b1;
		else if (shl_done)
			shl_pending <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// Handshakes and result writes
	////////////////////////////////////////////////////////////
	done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for a second cycle");

	write_in_region: assert property (@(posedge clk) disable iff (reset)
		write_en |-> (write_addr[ADDR_W-1:4] == lspele_base[ADDR_W-1:4])
			&& (write_addr[3:0] < LP_ORDER))
		else $error("Result write landed outside the lsp_ele region");

	no_relaunch: assert property (@(posedge clk) disable iff (reset)
		shl_ready |-> (!shl_pending || shl_done))
		else $error("Shifter launched again before its done pulse");

endmodule

`default_nettype wire

/* hw/lsp_extract_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsp_extract_top (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               start,
	input  logic [lsp_extract_pkg::ADDR_W-1:0] lsp_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0] freq_prev_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0] fg_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0] fg_sum_inv_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0] lspele_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0] host_addr,
	input  logic [lsp_extract_pkg::WORD_W-1:0] host_wdata,
	input  logic                               host_we,
	output logic                               done,
	output logic [lsp_extract_pkg::WORD_W-1:0] host_rdata
);
	import lsp_extract_pkg::*;

	// Engine to memory port A
	logic [ADDR_W-1:0]   read_addr, write_addr;
	logic [WORD_W-1:0]   read_data, write_data;
	logic                write_en;

	// Arithmetic operands and results
	logic [SAMPLE_W-1:0] mult_a, mult_b, msu_a, msu_b, add_a, add_b, add_out;
	logic [WORD_W-1:0]   msu_c, mult_out, msu_out;
	logic [WORD_W-1:0]   shl_a, shl_result;
	logic                shl_ready, shl_done;

	lsp_prev_extract u_seq (
		.clk(clk), .reset(reset), .start(start), .done(done),
		.lsp_base(lsp_base), .freq_prev_base(freq_prev_base), .fg_base(fg_base),
		.fg_sum_inv_base(fg_sum_inv_base), .lspele_base(lspele_base),
		.read_addr(read_addr), .read_data(read_data),
		.write_addr(write_addr), .write_data(write_data), .write_en(write_en),
		.mult_a(mult_a), .mult_b(mult_b), .mult_out(mult_out),
		.msu_a(msu_a), .msu_b(msu_b), .msu_c(msu_c), .msu_out(msu_out),
		.add_a(add_a), .add_b(add_b), .add_out(add_out),
		.shl_ready(shl_ready), .shl_a(shl_a), .shl_done(shl_done), .shl_result(shl_result)
	);

	basic_ops u_ops (
		.mult_a(mult_a), .mult_b(mult_b), .mult_out(mult_out),
		.msu_a(msu_a), .msu_b(msu_b), .msu_c(msu_c), .msu_out(msu_out),
		.add_a(add_a), .add_b(add_b), .add_out(add_out)
	);

	l_shl_unit u_shl (
		.clk(clk), .reset(reset),
		.shl_ready(shl_ready), .shl_a(shl_a),
		.shl_done(shl_done), .shl_result(shl_result)
	);

	// Engine only reads or writes on a given cycle, so one port address
	scratch_mem u_mem (
		.clk(clk),
		.a_addr(write_en ? write_addr : read_addr), .a_wdata(write_data),
		.a_we(write_en), .a_rdata(read_data),
		.b_addr(host_addr), .b_wdata(host_wdata), .b_we(host_we), .b_rdata(host_rdata)
	);

endmodule

`default_nettype wire

/* hw/lsp_prev_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module lsp_prev_extract (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 start,
	input  logic [lsp_extract_pkg::ADDR_W-1:0]   lsp_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0]   freq_prev_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0]   fg_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0]   fg_sum_inv_base,
	input  logic [lsp_extract_pkg::ADDR_W-1:0]   lspele_base,
	input  logic [lsp_extract_pkg::WORD_W-1:0]   read_data,
	input  logic [lsp_extract_pkg::WORD_W-1:0]   mult_out,
	input  logic [lsp_extract_pkg::WORD_W-1:0]   msu_out,
	input  logic [lsp_extract_pkg::SAMPLE_W-1:0] add_out,
	input  logic                                 shl_done,
	input  logic [lsp_extract_pkg::WORD_W-1:0]   shl_result,
	output logic                                 done,
	output logic [lsp_extract_pkg::ADDR_W-1:0]   read_addr,
	output logic [lsp_extract_pkg::ADDR_W-1:0]   write_addr,
	output logic [lsp_extract_pkg::WORD_W-1:0]   write_data,
	output logic                                 write_en,
	output logic [lsp_extract_pkg::SAMPLE_W-1:0] mult_a,
	output logic [lsp_extract_pkg::SAMPLE_W-1:0] mult_b,
	output logic [lsp_extract_pkg::SAMPLE_W-1:0] msu_a,
	output logic [lsp_extract_pkg::SAMPLE_W-1:0] msu_b,
	output logic [lsp_extract_pkg::WORD_W-1:0]   msu_c,
	output logic [lsp_extract_pkg::SAMPLE_W-1:0] add_a,
	output logic [lsp_extract_pkg::SAMPLE_W-1:0] add_b,
	output logic                                 shl_ready,
	output logic [lsp_extract_pkg::WORD_W-1:0]   shl_a
);
	import lsp_extract_pkg::*;

	enum logic [2:0] {S_IDLE, S_LOAD, S_TAP_FETCH, S_TAP_ACC, S_SCALE, S_SHL_WAIT}
		state, state_next;

	logic [SAMPLE_W-1:0] j, j_next;             // Coefficient index
	logic [SAMPLE_W-1:0] k, k_next;             // Tap index
	logic [WORD_W-1:0]   acc, acc_next;         // L_temp
	logic [SAMPLE_W-1:0] fp_stage, fp_stage_next;

	////////////////////////////////////////////////////////////
	// State registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			j     <= '0;
			k     <= '0;
		end
		else
		begin
			state <= state_next;
			j     <= j_next;
			k     <= k_next;
		end
	end

	always_ff @(posedge clk)
	begin
		acc      <= acc_next;
		fp_stage <= fp_stage_next;
	end

	////////////////////////////////////////////////////////////
	// Next state, addressing and datapath steering
	////////////////////////////////////////////////////////////
	always_comb
	begin
		state_next    = state;
		j_next        = j;
		k_next        = k;
		acc_next      = acc;
		fp_stage_next = fp_stage;
		done          = 1'b0;
		read_addr     = '0;
		write_addr    = '0;
		write_data    = '0;
		write_en      = 1'b0;
		mult_a        = '0;
		mult_b        = '0;
		msu_a         = '0;
		msu_b         = '0;
		msu_c         = '0;
		add_a         = '0;
		add_b         = '0;
		shl_ready     = 1'b0;
		shl_a         = '0;

		case (state)
			S_IDLE:
			begin
				read_addr = {lsp_base[ADDR_W-1:4], j[3:0]};   // Prefetch lsp[0]
				if (start)
					state_next = S_LOAD;
			end

			S_LOAD:
			begin
				if (j == LP_ORDER)
				begin
					j_next     = '0;
					done       = 1'b1;
					state_next = S_IDLE;
				end
				else
				begin
					// L_deposit_h(lsp[0]) for the first coefficient only
					if (j == '0)
						acc_next = {read_data[SAMPLE_W-1:0], {(WORD_W-SAMPLE_W){1'b0}}};
					read_addr  = {freq_prev_base[ADDR_W-1:6], j[3:0], k[1:0]};
					state_next = S_TAP_FETCH;
				end
			end

			S_TAP_FETCH:
			begin
				if (k == MA_NP)
				begin
					read_addr  = {fg_sum_inv_base[ADDR_W-1:4], j[3:0]};
					state_next = S_SCALE;
				end
				else
				begin
					fp_stage_next = read_data[SAMPLE_W-1:0];   // freq_prev[j][k]
					read_addr     = {fg_base[ADDR_W-1:6], j[3:0], k[1:0]};
					state_next    = S_TAP_ACC;
				end
			end

			S_TAP_ACC:
			begin
				msu_a    = fp_stage;
				msu_b    = read_data[SAMPLE_W-1:0];   // fg[j][k]
				msu_c    = acc;
				acc_next = msu_out;
				add_a    = k;
				add_b    = SAMPLE_W'(1);
				k_next   = add_out;
				// Next tap fetched while this one accumulates
				read_addr  = {freq_prev_base[ADDR_W-1:6], j[3:0], add_out[1:0]};
				state_next = S_TAP_FETCH;
			end

			S_SCALE:
			begin
				mult_a     = acc[WORD_W-1 -: SAMPLE_W];   // extract_h(L_temp)
				mult_b     = read_data[SAMPLE_W-1:0];
				shl_ready  = 1'b1;
				shl_a      = mult_out;
				state_next = S_SHL_WAIT;
			end

			S_SHL_WAIT:
			begin
				add_a = j;
				add_b = SAMPLE_W'(1);
				if (shl_done)
				begin
					write_addr = {lspele_base[ADDR_W-1:4], j[3:0]};
					write_data = {{(WORD_W-SAMPLE_W){1'b0}}, shl_result[WORD_W-1 -: SAMPLE_W]};
					write_en   = 1'b1;
					j_next     = add_out;
					k_next     = '0;
					// L_deposit_h(lsp[j+1])
					acc_next   = {read_data[SAMPLE_W-1:0], {(WORD_W-SAMPLE_W){1'b0}}};
					state_next = S_LOAD;
				end
				else
					read_addr = {lsp_base[ADDR_W-1:4], add_out[3:0]};   // lsp[j+1]
			end

			default: state_next = S_IDLE;
		endcase
	end

endmodule

`default_nettype wire

/* hw/scratch_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module scratch_mem (
	input  logic                               clk,
	// Port A, engine side
	input  logic [lsp_extract_pkg::ADDR_W-1:0] a_addr,
	input  logic [lsp_extract_pkg::WORD_W-1:0] a_wdata,
	input  logic                               a_we,
	output logic [lsp_extract_pkg::WORD_W-1:0] a_rdata,
	// Port B, host side
	input  logic [lsp_extract_pkg::ADDR_W-1:0] b_addr,
	input  logic [lsp_extract_pkg::WORD_W-1:0] b_wdata,
	input  logic                               b_we,
	output logic [lsp_extract_pkg::WORD_W-1:0] b_rdata
);
	import lsp_extract_pkg::*;

	logic [WORD_W-1:0] mem [MEM_DEPTH];

	////////////////////////////////////////////////////////////
	// Writes
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (b_we)
			mem[b_addr] <= b_wdata;
		if (a_we)
			mem[a_addr] <= a_wdata;   // Later assignment, so A wins a collision
	end

	// Registered reads, old data on a same-cycle write
	always_ff @(posedge clk)
	begin
		a_rdata <= mem[a_addr];
	end

	always_ff @(posedge clk)
	begin
		b_rdata <= mem[b_addr];
	end

endmodule

`default_nettype wire

/* hw/l_shl_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module l_shl_unit (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               shl_ready,
	input  logic [lsp_extract_pkg::WORD_W-1:0] shl_a,
	output logic                               shl_done,
	output logic [lsp_extract_pkg::WORD_W-1:0] shl_result
);
	import lsp_extract_pkg::*;

	logic [WORD_W-1:0]              shl_val;    // Operand, shifted in place
	logic [WORD_W-1:0]              shl_step;
	logic [$clog2(LSP_SHL+1)-1:0]   cnt;        // Shifts still to go
	logic                           busy;

	// One bit of L_shl; a sign change pins the value at the rail
	always_comb
	begin
		if (shl_val[WORD_W-1] != shl_val[WORD_W-2])
			shl_step = shl_val[WORD_W-1] ? {1'b1, {(WORD_W-1){1'b0}}}
				: {1'b0, {(WORD_W-1){1'b1}}};
		else
			shl_step = {shl_val[WORD_W-2:0], 1'b0};
	end

	////////////////////////////////////////////////////////////
	// Handshake and shift counter
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy     <= 1'b0;
			cnt      <= '0;
			shl_done <= 1'b0;
		end
		else
		begin
			shl_done <= 1'b0;
			if (shl_ready)
			begin
				busy <= 1'b1;
				cnt  <= ($clog2(LSP_SHL+1))'(LSP_SHL);
			end
			else if (busy)
			begin
				cnt <= cnt - 1'b1;
				if (cnt == 1)   // Last shift lands this edge
				begin
					busy     <= 1'b0;
					shl_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (shl_ready)
			shl_val <= shl_a;
		else if (busy)
			shl_val <= shl_step;
	end

	assign shl_result = shl_val;

endmodule

`default_nettype wire

/* hw/basic_ops.sv */
`timescale 1ns/1ps
`default_nettype none

module basic_ops (
	input  logic [lsp_extract_pkg::SAMPLE_W-1:0] mult_a,
	input  logic [lsp_extract_pkg::SAMPLE_W-1:0] mult_b,
	input  logic [lsp_extract_pkg::SAMPLE_W-1:0] msu_a,
	input  logic [lsp_extract_pkg::SAMPLE_W-1:0] msu_b,
	input  logic [lsp_extract_pkg::WORD_W-1:0]   msu_c,
	input  logic [lsp_extract_pkg::SAMPLE_W-1:0] add_a,
	input  logic [lsp_extract_pkg::SAMPLE_W-1:0] add_b,
	output logic [lsp_extract_pkg::WORD_W-1:0]   mult_out,
	output logic [lsp_extract_pkg::WORD_W-1:0]   msu_out,
	output logic [lsp_extract_pkg::SAMPLE_W-1:0] add_out
);
	import lsp_extract_pkg::*;

	logic [WORD_W-1:0] msu_prod;
	logic [WORD_W:0]   msu_diff;   // One guard bit for overflow detection

	// L_mult: doubled signed product, only -1 * -1 overflows
	function automatic logic [WORD_W-1:0] l_mult(
		input logic [SAMPLE_W-1:0] a,
		input logic [SAMPLE_W-1:0] b
	);
		logic signed [WORD_W-1:0] prod;
		logic [SAMPLE_W-1:0]      min_16;
		begin
			min_16 = {1'b1, {(SAMPLE_W-1){1'b0}}};
			prod   = $signed(a) * $signed(b);
			if ((a == min_16) && (b == min_16))
				l_mult = {1'b0, {(WORD_W-1){1'b1}}};   // MAX_32
			else
				l_mult = {prod[WORD_W-2:0], 1'b0};
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Multiply
	////////////////////////////////////////////////////////////
	always_comb
	begin
		mult_out = l_mult(mult_a, mult_b);
	end

	////////////////////////////////////////////////////////////
	// Multiply-subtract with 32-bit saturation
	////////////////////////////////////////////////////////////
	always_comb
	begin
		msu_prod = l_mult(msu_a, msu_b);
		msu_diff = {msu_c[WORD_W-1], msu_c} - {msu_prod[WORD_W-1], msu_prod};

		// Guard bit disagrees with sign bit on overflow
		if (msu_diff[WORD_W] != msu_diff[WORD_W-1])
		begin
			if (msu_diff[WORD_W])
				msu_out = {1'b1, {(WORD_W-1){1'b0}}};   // MIN_32
			else
				msu_out = {1'b0, {(WORD_W-1){1'b1}}};   // MAX_32
		end
		else
			msu_out = msu_diff[WORD_W-1:0];
	end

	// Loop counters only, wrap is harmless
	always_comb
	begin
		add_out = add_a + add_b;
	end

endmodule

`default_nettype wire

/* hw/lsp_extract_pkg.sv */
`default_nettype none

package lsp_extract_pkg;

	////////////////////////////////////////////////////////////
	// Memory geometry
	////////////////////////////////////////////////////////////
	localparam int ADDR_W    = 11;   // Word address into the scratch memory
	localparam int WORD_W    = 32;
	localparam int SAMPLE_W  = 16;   // Q15 sample in the low half of a word
	localparam int MEM_DEPTH = 2048;

	////////////////////////////////////////////////////////////
	// Algorithm constants
	////////////////////////////////////////////////////////////
	localparam int LP_ORDER  = 10;   // LSP coefficients per frame
	localparam int MA_NP     = 4;    // MA predictor taps

	// Left shift applied to the scaled value before extract_h
	localparam int LSP_SHL   = 3;

endpackage

`default_nettype wire
